/* Makefile */
TOP := spi_top_tb
OBJ := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f spi_top.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* hdl/spi_apb_regs.sv */
// APB register block of the SPI master. Decodes accesses, holds the
// control, divider and interrupt enable registers, builds status and
// flag words, drives the FIFO strobes and the interrupt line.
`timescale 1ns/1ns

`include "spi_config.svh"

module spi_apb_regs
(
  input  logic                   pclk,
  input  logic                   preset_n,
  input  spi_pkg::apb_req_t      apb_req,
  output spi_pkg::apb_rsp_t      apb_rsp,
  output logic                   rst_n_sync,
  output spi_pkg::spi_cfg_t      cfg,
  output logic                   tx_push,
  output logic [`SPI_DATA_W-1:0] tx_wdata,
  output logic                   tx_clear,
  output logic                   rx_clear,
  output logic                   rx_pop,
  input  logic [`SPI_DATA_W-1:0] rx_rdata,
  input  spi_pkg::fifo_flags_t   tx_flags,
  input  spi_pkg::fifo_flags_t   rx_flags,
  input  logic [`SPI_PTR_W:0]    tx_level,
  input  logic [`SPI_PTR_W:0]    rx_level,
  input  logic                   xfer_done,
  input  logic                   busy,
  output logic                   irq
);
  import spi_pkg::*;

  localparam logic [`SPI_DATA_W-1:0] CR_RST = `SPI_CR_RESET;

  logic                   sync_1;
  logic                   sync_2;
  logic                   access;
  logic                   ro_write;
  logic                   acc_err;
  logic                   wr_en;
  logic                   rd_en;
  logic                   wr_cr;
  logic                   wr_br;
  logic                   wr_ier;
  logic                   wr_isr;
  logic                   wr_txd;
  logic                   txd_drop;
  logic [`SPI_DATA_W-1:0] cr_rd;
  logic [`SPI_DATA_W-1:0] rd_mux;
  spi_irq_t               ier;
  spi_irq_t               ris;
  spi_irq_t               isr;

  // ================================================
  // reset synchronizer, async assert, sync release
  // ================================================
  always_ff @(posedge pclk or negedge preset_n)
  begin
    if (!preset_n)
    begin
      sync_1 <= 1'b0;
      sync_2 <= 1'b0;
    end
    else
    begin
      sync_1 <= 1'b1;
      sync_2 <= sync_1;
    end
  end

  assign rst_n_sync = sync_2;

  // ================================================
  // access decode
  // ================================================
  assign access   = apb_req.psel & apb_req.penable;
  // SR, RIS and RXD are read-only
  assign ro_write = apb_req.pwrite & ((apb_req.paddr == `SPI_SR_ADDR) |
                                      (apb_req.paddr == `SPI_RIS_ADDR) |
                                      (apb_req.paddr == `SPI_RXD_ADDR));
  // misaligned, partial strobe or read-only write
  assign acc_err  = (|apb_req.paddr[1:0]) | ~(&apb_req.pstrb) | ro_write;
  assign wr_en    = access & apb_req.pwrite & ~acc_err;
  assign rd_en    = access & ~apb_req.pwrite & ~acc_err;

  assign wr_cr    = wr_en & (apb_req.paddr == `SPI_CR_ADDR);
  assign wr_br    = wr_en & (apb_req.paddr == `SPI_BR_ADDR);
  assign wr_ier   = wr_en & (apb_req.paddr == `SPI_IER_ADDR);
  assign wr_isr   = wr_en & (apb_req.paddr == `SPI_ISR_ADDR);
  assign wr_txd   = wr_en & (apb_req.paddr == `SPI_TXD_ADDR);

  // txd write into a full FIFO is dropped here
  assign tx_push  = wr_txd & ~tx_flags.full;
  assign txd_drop = wr_txd & tx_flags.full;
  assign tx_wdata = apb_req.pwdata;
  assign rx_pop   = rd_en & (apb_req.paddr == `SPI_RXD_ADDR);

  // ================================================
  // control, divider and enable registers
  // ================================================
  always_ff @(posedge pclk or negedge rst_n_sync)
  begin
    if (!rst_n_sync)
    begin
      cfg.enable    <= CR_RST[0];
      cfg.cpol      <= CR_RST[1];
      cfg.cpha      <= CR_RST[2];
      cfg.lsb_first <= CR_RST[3];
      cfg.datalen   <= CR_RST[8:4];
      cfg.ss_sel    <= CR_RST[10:9];
      cfg.divider   <= `SPI_BR_RESET;
      ier           <= '0;
      tx_clear      <= 1'b0;
      rx_clear      <= 1'b0;
    end
    else
    begin
      // clear bits live for one cycle only
      tx_clear <= wr_cr & apb_req.pwdata[11];
      rx_clear <= wr_cr & apb_req.pwdata[12];
      if (wr_cr)
      begin
        cfg.enable    <= apb_req.pwdata[0];
        cfg.cpol      <= apb_req.pwdata[1];
        cfg.cpha      <= apb_req.pwdata[2];
        cfg.lsb_first <= apb_req.pwdata[3];
        cfg.datalen   <= apb_req.pwdata[8:4];
        cfg.ss_sel    <= apb_req.pwdata[10:9];
      end
      if (wr_br)
        cfg.divider <= apb_req.pwdata[`SPI_BR_W-1:0];
      if (wr_ier)
        ier <= spi_irq_t'(apb_req.pwdata[$bits(spi_irq_t)-1:0]);
    end
  end

  // ================================================
  // raw flags
  // ================================================
  always_ff @(posedge pclk or negedge rst_n_sync)
  begin
    if (!rst_n_sync)
      ris <= '0;
    else
    begin
      // level flags follow the fifos
      ris.tx_empty     <= tx_flags.empty;
      ris.rx_not_empty <= ~rx_flags.empty;
      ris.rx_full      <= rx_flags.full;
      // sticky until any ISR write, new event wins
      ris.tx_overflow  <= txd_drop | (ris.tx_overflow & ~wr_isr);
      ris.rx_overflow  <= rx_flags.overflow | (ris.rx_overflow & ~wr_isr);
      ris.xfer_done    <= xfer_done | (ris.xfer_done & ~wr_isr);
    end
  end

  assign isr = spi_irq_t'(ris & ier);
  assign irq = |isr;

  // ================================================
  // read path, zero wait states
  // ================================================
  // clear bits always read back as zero
  assign cr_rd = `SPI_DATA_W'({2'b00, cfg.ss_sel, cfg.datalen, cfg.lsb_first,
                               cfg.cpha, cfg.cpol, cfg.enable});

  always_comb
  begin
    case (apb_req.paddr)
      `SPI_CR_ADDR:  rd_mux = cr_rd;
      `SPI_BR_ADDR:  rd_mux = `SPI_DATA_W'(cfg.divider);
      `SPI_IER_ADDR: rd_mux = `SPI_DATA_W'(ier);
      `SPI_SR_ADDR:  rd_mux = `SPI_DATA_W'({busy, rx_level, tx_level});
      `SPI_RIS_ADDR: rd_mux = `SPI_DATA_W'(ris);
      `SPI_ISR_ADDR: rd_mux = `SPI_DATA_W'(isr);
      // empty rx fifo reads as zero
      `SPI_RXD_ADDR: rd_mux = rx_flags.empty ? '0 : rx_rdata;
      default:       rd_mux = '0;
    endcase
  end

  assign apb_rsp.prdata  = rd_en ? rd_mux : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & acc_err;

endmodule

/* hdl/spi_engine.sv */
// SPI master transfer engine. Pulls words from the TX FIFO, generates
// sclk as a pclk-based toggle, shifts mosi and samples miso per cpol,
// cpha and bit order, and hands each received word to the RX FIFO.
`timescale 1ns/1ns

`include "spi_config.svh"

module spi_engine
(
  input  logic                   pclk,
  input  logic                   rst_n,
  input  spi_pkg::spi_cfg_t      cfg,
  input  logic [`SPI_DATA_W-1:0] tx_data,
  input  logic                   tx_empty,
  output logic                   tx_pop,
  output logic                   rx_push,
  output logic [`SPI_DATA_W-1:0] rx_data,
  output logic                   xfer_done,
  output logic                   busy,
  output logic                   sclk,
  output logic                   mosi,
  input  logic                   miso,
  output logic [3:0]             ss_n
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_FINISH
  } state_t;

  state_t                 state;
  // pclk cycles inside the current half period
  logic [`SPI_BR_W-1:0]   div_cnt;
  // sclk edges done, two per bit
  logic [5:0]             edge_cnt;
  logic [`SPI_DATA_W-1:0] tx_sh;
  logic [`SPI_DATA_W-1:0] rx_sh;
  logic [4:0]             align;
  logic                   start;
  logic                   half_end;
  logic                   last_edge;
  logic                   sample_edge;
  logic                   shift_edge;

  // ================================================
  // sequencing
  // ================================================
  assign start     = (state == ST_IDLE) & cfg.enable & ~tx_empty;
  assign half_end  = (state == ST_SHIFT) & (div_cnt == cfg.divider);
  // edge 2*datalen+1 closes the word
  assign last_edge = (edge_cnt == {cfg.datalen, 1'b1});

  // cpha 0 samples on leading (even) edges, cpha 1 on trailing
  assign sample_edge = half_end & (edge_cnt[0] == cfg.cpha);
  // first bit is already on mosi, so no shift on edge 0
  assign shift_edge  = half_end & (edge_cnt[0] != cfg.cpha) & (edge_cnt != '0);

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      div_cnt  <= '0;
      edge_cnt <= '0;
      sclk     <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          // park sclk at idle level
          sclk     <= cfg.cpol;
          div_cnt  <= '0;
          edge_cnt <= '0;
          if (start)
            state <= ST_SHIFT;
        end
        ST_SHIFT:
        begin
          if (half_end)
          begin
            div_cnt  <= '0;
            sclk     <= ~sclk;
            edge_cnt <= edge_cnt + 1'b1;
            if (last_edge)
              state <= ST_FINISH;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        // one cycle to hand the word over
        ST_FINISH: state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // ================================================
  // shift registers
  // ================================================
  // msb-first word is moved up so bit datalen sits at the top
  assign align = 5'(`SPI_DATA_W - 1) - cfg.datalen;

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
      tx_sh <= '0;
    else if (start)
      tx_sh <= cfg.lsb_first ? tx_data : (tx_data << align);
    else if (shift_edge)
      tx_sh <= cfg.lsb_first ? (tx_sh >> 1) : (tx_sh << 1);
  end

  // msb-first fills from bit 0, lsb-first from the top
  always_ff @(posedge pclk)
  begin
    if (start)
      rx_sh <= '0;
    else if (sample_edge)
      rx_sh <= cfg.lsb_first ? {miso, rx_sh[`SPI_DATA_W-1:1]}
                             : {rx_sh[`SPI_DATA_W-2:0], miso};
  end

  assign mosi    = cfg.lsb_first ? tx_sh[0] : tx_sh[`SPI_DATA_W-1];
  // right-align lsb-first words
  assign rx_data = cfg.lsb_first ? (rx_sh >> align) : rx_sh;

  // ================================================
  // handshakes and slave select
  // ================================================
  assign tx_pop    = start;
  assign rx_push   = (state == ST_FINISH);
  assign xfer_done = (state == ST_FINISH);
  assign busy      = (state != ST_IDLE);

  always_comb
  begin
    ss_n = '1;
    if (busy)
      ss_n[cfg.ss_sel] = 1'b0;
  end

endmodule

/* hdl/spi_fifo.sv */
// Synchronous FIFO with head-of-queue output, level count and
// one-cycle overflow and underflow flags. Used for TX and RX.
`timescale 1ns/1ns

`include "spi_config.svh"

module spi_fifo
#(
  parameter int SPI_FIFO_DEPTH = `SPI_FIFO_DEPTH
)
(
  input  logic                   pclk,
  input  logic                   rst_n,
  input  logic                   clear,
  input  logic                   push,
  input  logic                   pop,
  input  logic [`SPI_DATA_W-1:0] wdata,
  output logic [`SPI_DATA_W-1:0] rdata,
  output spi_pkg::fifo_flags_t   flags,
  output logic [`SPI_PTR_W:0]    level
);

  localparam int PTR_W = $clog2(SPI_FIFO_DEPTH);
  localparam int LVL_W = `SPI_PTR_W + 1;

  logic [`SPI_DATA_W-1:0] mem [SPI_FIFO_DEPTH];
  // msb of each pointer is the wrap bit
  logic [PTR_W:0]         wr_ptr;
  logic [PTR_W:0]         rd_ptr;
  logic [PTR_W:0]         used;
  logic                   wr_en;
  logic                   rd_en;

  // full and empty refuse the access
  assign wr_en = push & ~flags.full;
  assign rd_en = pop & ~flags.empty;

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else if (clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage
  always_ff @(posedge pclk)
  begin
    if (wr_en)
      mem[wr_ptr[PTR_W-1:0]] <= wdata;
  end

  assign rdata = mem[rd_ptr[PTR_W-1:0]];

  // same index, different wrap means full
  assign flags.full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                           (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign flags.empty     = (wr_ptr == rd_ptr);
  assign flags.overflow  = push & flags.full;
  assign flags.underflow = pop & flags.empty;

  assign used  = wr_ptr - rd_ptr;
  assign level = LVL_W'(used);

endmodule

/* hdl/spi_pkg.sv */
// Shared types of the SPI master: APB request and response,
// engine configuration, FIFO flags and the interrupt flag word.

`include "spi_config.svh"

package spi_pkg;

  // ================================================
  // APB slave port
  // ================================================
  // master to slave, setup then access phase
  typedef struct packed {
    logic [`SPI_ADDR_W-1:0]   paddr;
    logic                     pwrite;
    logic [`SPI_DATA_W-1:0]   pwdata;
    logic [`SPI_DATA_W/8-1:0] pstrb;
    logic                     psel;
    logic                     penable;
  } apb_req_t;

  // slave to master, valid in the access cycle
  typedef struct packed {
    logic [`SPI_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  // ================================================
  // register block to engine
  // ================================================
  typedef struct packed {
    logic [`SPI_BR_W-1:0] divider;
    logic [1:0]           ss_sel;
    // bits per word minus one
    logic [4:0]           datalen;
    logic                 lsb_first;
    logic                 cpha;
    logic                 cpol;
    logic                 enable;
  } spi_cfg_t;

  // fifo status, overflow and underflow last one cycle
  typedef struct packed {
    logic full;
    logic empty;
    logic overflow;
    logic underflow;
  } fifo_flags_t;

  // RIS, IER and ISR layout, tx_empty is bit 0
  typedef struct packed {
    logic xfer_done;
    logic rx_overflow;
    logic tx_overflow;
    logic rx_full;
    logic rx_not_empty;
    logic tx_empty;
  } spi_irq_t;

endpackage

/* hdl/spi_top.sv */
// Top level of the SPI master peripheral. APB register block, TX and
// RX FIFOs and the transfer engine, all on pclk.
`timescale 1ns/1ns

`include "spi_config.svh"

module spi_top
(
  input  logic              pclk,
  input  logic              preset_n,
  input  spi_pkg::apb_req_t apb_req,
  output spi_pkg::apb_rsp_t apb_rsp,
  output logic              irq,
  output logic              sclk,
  output logic              mosi,
  output logic [3:0]        ss_n,
  input  logic              miso
);
  import spi_pkg::*;

  logic                   rst_n_sync;
  spi_cfg_t               cfg;
  // register block to fifos
  logic                   tx_push;
  logic [`SPI_DATA_W-1:0] tx_wdata;
  logic                   tx_clear;
  logic                   rx_clear;
  logic                   rx_pop;
  logic [`SPI_DATA_W-1:0] rx_rdata;
  // fifo status back to registers
  fifo_flags_t            tx_flags;
  fifo_flags_t            rx_flags;
  logic [`SPI_PTR_W:0]    tx_level;
  logic [`SPI_PTR_W:0]    rx_level;
  // engine side
  logic [`SPI_DATA_W-1:0] tx_data;
  logic                   tx_pop;
  logic                   rx_push;
  logic [`SPI_DATA_W-1:0] rx_data;
  logic                   xfer_done;
  logic                   busy;

  spi_apb_regs u_regs (.*);

  spi_fifo #(.SPI_FIFO_DEPTH(`SPI_FIFO_DEPTH)) u_tx_fifo
  (
    .pclk(pclk), .rst_n(rst_n_sync), .clear(tx_clear), .push(tx_push), .pop(tx_pop),
    .wdata(tx_wdata), .rdata(tx_data), .flags(tx_flags), .level(tx_level)
  );

  spi_fifo #(.SPI_FIFO_DEPTH(`SPI_FIFO_DEPTH)) u_rx_fifo
  (
    .pclk(pclk), .rst_n(rst_n_sync), .clear(rx_clear), .push(rx_push), .pop(rx_pop),
    .wdata(rx_data), .rdata(rx_rdata), .flags(rx_flags), .level(rx_level)
  );

  spi_engine u_engine
  (
    .pclk(pclk), .rst_n(rst_n_sync), .cfg(cfg), .tx_data(tx_data),
    .tx_empty(tx_flags.empty), .tx_pop(tx_pop), .rx_push(rx_push), .rx_data(rx_data),
    .xfer_done(xfer_done), .busy(busy), .sclk(sclk), .mosi(mosi), .miso(miso), .ss_n(ss_n)
  );

endmodule

/* include/spi_config.svh */
// Build-time constants for the SPI master peripheral.
// Included by the package, the RTL and the testbench.

`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// ================================================
// widths and sizes
// ================================================
// data and register word width
`define SPI_DATA_W      32
// entries per FIFO, power of two
`define SPI_FIFO_DEPTH  8
// log2 of the FIFO depth
`define SPI_PTR_W       3
// shift clock divider width
`define SPI_BR_W        8
// APB address width
`define SPI_ADDR_W      5

// ================================================
// register map, byte offsets
// ================================================
`define SPI_CR_ADDR     5'h00
`define SPI_BR_ADDR     5'h04
`define SPI_IER_ADDR    5'h08
`define SPI_SR_ADDR     5'h0C
`define SPI_RIS_ADDR    5'h10
`define SPI_ISR_ADDR    5'h14
`define SPI_TXD_ADDR    5'h18
`define SPI_RXD_ADDR    5'h1C

// reset values, datalen = 7 gives 8-bit words
`define SPI_CR_RESET    32'h0000_0070
`define SPI_BR_RESET    8'h00

`endif

/* sim/spi_top_assertions.sv */
// Concurrent checks on the SPI master top level, attached by bind.
// Watches the APB ready line, slave selects and TX FIFO writes.
`timescale 1ns/1ns

module spi_top_assertions
(
  input logic                 pclk,
  input logic                 rst_n_sync,
  input spi_pkg::apb_rsp_t    apb_rsp,
  input logic [3:0]           ss_n,
  input logic                 tx_push,
  input spi_pkg::fifo_flags_t tx_flags
);

  // zero wait states on APB
  a_pready: assert property (@(posedge pclk) disable iff (!rst_n_sync)
    apb_rsp.pready)
    else $error("pready went low");

  // only one slave addressed at a time
  a_one_ss: assert property (@(posedge pclk) disable iff (!rst_n_sync)
    $onehot0(~ss_n))
    else $error("more than one slave select active");

  // full TX FIFO must never see a push
  a_no_full_push: assert property (@(posedge pclk) disable iff (!rst_n_sync)
    !(tx_push && tx_flags.full))
    else $error("push into a full TX FIFO");

endmodule

bind spi_top spi_top_assertions u_assertions
(
  .pclk(pclk), .rst_n_sync(rst_n_sync), .apb_rsp(apb_rsp), .ss_n(ss_n),
  .tx_push(tx_push), .tx_flags(tx_flags)
);

/* sim/spi_top_stim.txt */
# columns: op addr data expect name, hex; W write, E and S writes expecting pslverr (S partial
# pstrb), R read, B write data expect times, T loopback with addr as CR word, I irq level
R 00 00000000 00000070 reset
R 04 00000000 00000000 reset
R 08 00000000 00000000 reset
W 00 FFFFFFFE 00000000 readback
R 00 00000000 000007FE readback
W 04 FFFFFFFF 00000000 readback
R 04 00000000 000000FF readback
W 08 FFFFFFFF 00000000 readback
R 08 00000000 0000003F readback
W 08 00000000 00000000 readback
E 01 00000001 00000000 errors
S 04 00000012 00000000 errors
E 0C 00000000 00000000 errors
R 00 00000000 000007FE errors
R 04 00000000 000000FF errors
B 18 0000A5A5 00000009 overflow
R 0C 00000000 00000008 overflow
R 10 00000000 00000008 overflow
R 1C 00000000 00000000 overflow
W 00 00000870 00000000 overflow
W 14 00000000 00000000 overflow
W 04 00000001 00000000 loopback
T 71 123456A5 000000A5 loopback
T 73 0000003C 0000003C loopback
T 75 FFFFFF81 00000081 loopback
T 77 0000FF5A 0000005A loopback
T 79 000000C3 000000C3 loopback
T 7B 87654321 00000021 loopback
T 7D 00000001 00000001 loopback
T 7F 000000FE 000000FE loopback
T 01 FFFFFFFF 00000001 loopback
T 0F 00000002 00000000 loopback
T 101 DEADBEEF 0001BEEF loopback
T 10B 00012345 00012345 loopback
T 1F1 CAFEF00D CAFEF00D loopback
T 5FD 80000001 80000001 loopback
W 14 00000000 00000000 irq
W 08 00000020 00000000 irq
I 00 00000000 00000000 irq
T 71 000000AA 000000AA irq
I 00 00000000 00000001 irq
W 14 00000000 00000000 irq
I 00 00000000 00000000 irq
W 08 00000000 00000000 irq
T 71 00000055 00000055 irq
I 00 00000000 00000000 irq

/* sim/spi_top_tb.sv */
// Testbench for the SPI master peripheral. Loads operations from the
// stim file, drives APB, loops mosi back to miso and checks results.
`timescale 1ns/1ns

`include "spi_config.svh"

module spi_top_tb;
  import spi_pkg::*;

  // worst-case word, max divider and 32 bits, plus start and finish
  localparam int WORD_MAX = 2 * `SPI_DATA_W * (1 << `SPI_BR_W) + 2;
  // generous budget for the APB accesses of one stim line
  localparam int LINE_MAX = 32;

  logic       pclk;
  logic       preset_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  logic       irq;
  logic       sclk;
  logic       mosi;
  logic       miso;
  logic [3:0] ss_n;

  // stim table, one entry per line
  string       op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] expv_q[$];
  string       name_q[$];

  string cur_test = "";
  int    test_checks = 0;
  int    test_errs = 0;
  int    n_tests = 0;
  int    n_checks = 0;
  int    n_errs = 0;
  int    cycles = 0;
  int    limit = 0;

  // sclk and select activity of the current word
  int         sclk_edges = 0;
  logic       sclk_prev = 1'b0;
  logic [3:0] ss_seen = 4'hF;

  // loopback
  assign miso = mosi;

  spi_top i_spi_top
  (
    .pclk(pclk), .preset_n(preset_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .irq(irq), .sclk(sclk), .mosi(mosi), .ss_n(ss_n), .miso(miso)
  );

  // ==================================================
  // clock and watchdog
  // ==================================================
  initial
  begin
    pclk = 1'b0;
    forever
      #5 pclk = ~pclk;
  end

  always @(posedge pclk)
  begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // count sclk toggles while a slave is selected
  always @(negedge pclk)
  begin
    if (ss_n != 4'hF && sclk !== sclk_prev)
      sclk_edges++;
    sclk_prev = sclk;
    // every select line seen low
    ss_seen = ss_seen & ss_n;
  end

  // ==================================================
  // helpers
  // ==================================================
  task automatic report_error(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    test_errs++;
    $display("ERROR %s (%s): expected %h, actual %h", cur_test, what, exp, act);
  endtask

  // print the finished test and fold it into the totals
  task automatic close_test();
    if (cur_test != "")
    begin
      n_tests++;
      n_checks += test_checks;
      n_errs += test_errs;
      $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    end
    test_checks = 0;
    test_errs = 0;
  endtask

  // one APB transfer, setup then access phase
  task automatic apb_access(input logic wr, input logic [`SPI_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            output logic [31:0] rdata, output logic err);
    @(posedge pclk);
    #1;
    apb_req.paddr   = addr;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    apb_req.pstrb   = strb;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge pclk);
    #1;
    apb_req.penable = 1'b1;
    // sample mid-cycle, clear of the completing edge
    @(negedge pclk);
    while (!apb_rsp.pready)
      @(negedge pclk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge pclk);
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_reg(input logic [`SPI_ADDR_W-1:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, wdata, strb, rdata, err);
    test_checks++;
    if (err !== exp_err)
      report_error("pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic read_reg(input logic [`SPI_ADDR_W-1:0] addr, output logic [31:0] rdata);
    logic err;
    apb_access(1'b0, addr, '0, 4'hF, rdata, err);
    test_checks++;
    if (err !== 1'b0)
      report_error("pslverr", 32'd0, 32'(err));
  endtask

  // configure, send one word, wait for it to land in RX, compare
  task automatic run_loopback(input logic [31:0] cr, input logic [31:0] word,
                              input logic [31:0] expv);
    logic [31:0] sr;
    logic [31:0] rdata;
    logic [3:0]  ss_exp;
    int          edges_exp;
    // selected line low, two sclk half periods per bit
    ss_exp     = ~(4'b0001 << cr[10:9]);
    edges_exp  = 2 * (int'(cr[8:4]) + 1);
    sclk_edges = 0;
    ss_seen    = 4'hF;
    write_reg(`SPI_CR_ADDR, cr, 4'hF, 1'b0);
    write_reg(`SPI_TXD_ADDR, word, 4'hF, 1'b0);
    // rx level 1 and engine idle
    read_reg(`SPI_SR_ADDR, sr);
    while (sr[7:4] != 4'd1 || sr[8])
      read_reg(`SPI_SR_ADDR, sr);
    read_reg(`SPI_RXD_ADDR, rdata);
    test_checks++;
    if (rdata !== expv)
      report_error("rxd", expv, rdata);
    test_checks++;
    if (sclk_edges != edges_exp)
      report_error("sclk edges", 32'(edges_exp), 32'(sclk_edges));
    test_checks++;
    if (sclk !== cr[1])
      report_error("sclk idle", 32'(cr[1]), 32'(sclk));
    test_checks++;
    if (ss_seen !== ss_exp)
      report_error("ss_n active", 32'(ss_exp), 32'(ss_seen));
    test_checks++;
    if (ss_n !== 4'hF)
      report_error("ss_n idle", 32'hF, 32'(ss_n));
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial
  begin
    int                     fd;
    int                     n;
    string                  line;
    string                  op;
    string                  name;
    logic [31:0]            addr;
    logic [31:0]            data;
    logic [31:0]            expv;
    logic [31:0]            rdata;
    logic [`SPI_ADDR_W-1:0] a;

    preset_n = 1'b0;
    apb_req  = '0;

    // load the stim table
    fd = $fopen("sim/spi_top_stim.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stim file sim/spi_top_stim.txt");
      n_errs++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        // skip comment and blank lines
        if (n > 1 && line.getc(0) != "#")
        begin
          if ($sscanf(line, "%s %h %h %h %s", op, addr, data, expv, name) == 5)
          begin
            op_q.push_back(op);
            addr_q.push_back(addr);
            data_q.push_back(data);
            expv_q.push_back(expv);
            name_q.push_back(name);
          end
        end
      end
      $fclose(fd);
    end

    // watchdog budget from the table
    limit = 200;
    foreach (op_q[i])
    begin
      limit += LINE_MAX;
      if (op_q[i] == "T")
        limit += WORD_MAX;
      else if (op_q[i] == "B")
        limit += LINE_MAX * int'(expv_q[i]);
    end

    repeat (2) @(posedge pclk);
    #1;
    preset_n = 1'b1;
    // two-stage synchronizer in the register block
    repeat (3) @(posedge pclk);

    foreach (op_q[i])
    begin
      if (name_q[i] != cur_test)
      begin
        close_test();
        cur_test = name_q[i];
      end
      a = addr_q[i][`SPI_ADDR_W-1:0];
      if (op_q[i] == "W")
        write_reg(a, data_q[i], 4'hF, 1'b0);
      else if (op_q[i] == "E")
        write_reg(a, data_q[i], 4'hF, 1'b1);
      else if (op_q[i] == "S")
        write_reg(a, data_q[i], 4'h3, 1'b1);
      else if (op_q[i] == "B")
      begin
        repeat (expv_q[i])
          write_reg(a, data_q[i], 4'hF, 1'b0);
      end
      else if (op_q[i] == "R")
      begin
        read_reg(a, rdata);
        test_checks++;
        if (rdata !== expv_q[i])
          report_error($sformatf("read %h", a), expv_q[i], rdata);
      end
      else if (op_q[i] == "T")
        run_loopback(addr_q[i], data_q[i], expv_q[i]);
      else if (op_q[i] == "I")
      begin
        @(negedge pclk);
        test_checks++;
        if (irq !== expv_q[i][0])
          report_error("irq", expv_q[i], 32'(irq));
      end
      else
      begin
        $display("unknown operation %s in the stim file", op_q[i]);
        test_errs++;
      end
    end
    close_test();

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errs);
    if (n_errs == 0 && n_checks > 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* spi_top.f */
+incdir+include
hdl/spi_pkg.sv
hdl/spi_fifo.sv
hdl/spi_engine.sv
hdl/spi_apb_regs.sv
hdl/spi_top.sv
sim/spi_top_assertions.sv
sim/spi_top_tb.sv
